/* build.f */
hw/bps_pkg.sv
hw/message_ram.sv
hw/field_loader.sv
hw/narrowing_fifo.sv
hw/field_storer.sv
hw/bps_sequencer.sv
hw/bps_top.sv
sim/bps_tb.sv

/* Bender.yml */
package:
  name: bps_field_buffer

sources:
  - hw/bps_pkg.sv
  - hw/message_ram.sv
  - hw/field_loader.sv
  - hw/narrowing_fifo.sv
  - hw/field_storer.sv
  - hw/bps_sequencer.sv
  - hw/bps_top.sv
  - target: test
    files:
      - sim/bps_tb.sv

/* sim/bps_tb.sv */
`default_nettype none

module bps_tb import bps_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIELD_WIDTH    = 4;
    localparam int FIELD_HEIGHT   = 2;
    localparam int ENTRIES        = FIELD_WIDTH * FIELD_HEIGHT;
    localparam int TIMEOUT_CYCLES = ENTRIES * 4 * 20 * 3 + 1000;

    logic        clk;
    logic        rst;
    opcode_t     opcode;
    logic [63:0] addr_base;
    logic        stall;
    logic        mc_req_ld;
    logic        mc_req_st;
    vadr_t       mc_req_vadr;
    word_t       mc_req_wrd_rdctl;
    logic        mc_req_stall;
    word_t       mc_rsp_data;
    logic        mc_rsp_push;
    logic        mc_rsp_stall;

    word_t       mem_model [vadr_t];  // Sparse external memory
    word_t       load_img [2*ENTRIES];
    word_t       rsp_data_q [$];
    int          rsp_time_q [$];
    int          cycle;
    int          last_ready;
    int          delay;
    int          ready;
    logic [31:0] fill_rng;
    logic [31:0] model_rng;
    vadr_t       region;
    vadr_t       exp_addr;
    word_t       exp_data;
    string       test_name;
    int          errors;
    int          checks;
    int          ld_count;
    int          st_count;
    logic        stall_sampled;

    bps_top #(
        .FIELD_WIDTH  (FIELD_WIDTH),
        .FIELD_HEIGHT (FIELD_HEIGHT)
    ) i_bps_top (
        .clk              (clk),
        .rst              (rst),
        .opcode           (opcode),
        .addr_base        (addr_base),
        .stall            (stall),
        .mc_req_ld        (mc_req_ld),
        .mc_req_st        (mc_req_st),
        .mc_req_vadr      (mc_req_vadr),
        .mc_req_wrd_rdctl (mc_req_wrd_rdctl),
        .mc_req_stall     (mc_req_stall),
        .mc_rsp_data      (mc_rsp_data),
        .mc_rsp_push      (mc_rsp_push),
        .mc_rsp_stall     (mc_rsp_stall)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fill_rand();
        fill_rng = xorshift32(fill_rng);
        return fill_rng;
    endfunction

    function automatic logic [31:0] model_rand();
        model_rng = xorshift32(model_rng);
        return model_rng;
    endfunction

    // Loaded bytes cut to their low 6 bits in words 0 and 1 and zero words after them
    function automatic word_t expected_store_word(input int entry, input int word);
        word_t src;
        word_t res;
        res = '0;
        if (word < 2) begin
            src = load_img[2*entry + word];
            for (int b = 0; b < 8; b++) begin
                res[8*b +: 8] = {2'b00, src[8*b +: 6]};
            end
        end
        return res;
    endfunction

    task automatic compare_bit(input string sig, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: %s expected %b actual %b", test_name, sig, expected, actual);
        end
    endtask

    task automatic fill_memory();
        word_t w;
        vadr_t a;
        for (int i = 0; i < 2 * ENTRIES; i++) begin
            w = {fill_rand(), fill_rand()};
            a = region + vadr_t'(ENTRY_STRIDE * (i / 2)) + vadr_t'(8 * (i % 2));
            mem_model[a] = w;
            load_img[i]  = w;
        end
    endtask

    task automatic run_op(input opcode_t op, input string name);
        test_name = name;
        ld_count  = 0;
        st_count  = 0;
        opcode    = op;
        @(negedge clk);
        opcode = OP_IDLE;
        compare_bit("stall", 1'b1, stall);
        while (stall !== 1'b0) begin
            @(negedge clk);
        end
        compare_bit("mc_rsp_stall", 1'b0, mc_rsp_stall);
        checks += 2;
        if (ld_count != ((op == OP_LOAD) ? 2 * ENTRIES : 0)) begin
            errors++;
            $display("Error %s: read strobes expected %0d actual %0d", name,
                     (op == OP_LOAD) ? 2 * ENTRIES : 0, ld_count);
        end
        if (st_count != ((op == OP_STORE) ? 4 * ENTRIES : 0)) begin
            errors++;
            $display("Error %s: write strobes expected %0d actual %0d", name,
                     (op == OP_STORE) ? 4 * ENTRIES : 0, st_count);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        stall_sampled <= mc_req_stall;
    end

    // In-order read responses after 1 to 4 cycles under random back-pressure
    initial begin
        mc_req_stall = 1'b0;
        mc_rsp_push  = 1'b0;
        mc_rsp_data  = '0;
        model_rng    = xorshift32(32'h4638);
        cycle        = 0;
        last_ready   = 0;
        forever begin
            @(negedge clk);
            cycle++;
            if (mc_req_ld === 1'b1) begin
                delay = 1 + int'(model_rand() % 4);
                ready = cycle + delay;
                if (ready <= last_ready) begin
                    ready = last_ready + 1;
                end
                last_ready = ready;
                rsp_data_q.push_back(mem_model.exists(mc_req_vadr) ? mem_model[mc_req_vadr] : '0);
                rsp_time_q.push_back(ready);
            end
            if (mc_req_st === 1'b1) begin
                mem_model[mc_req_vadr] = mc_req_wrd_rdctl;
            end
            if (rsp_time_q.size() > 0 && rsp_time_q[0] <= cycle) begin
                mc_rsp_push = 1'b1;
                mc_rsp_data = rsp_data_q.pop_front();
                void'(rsp_time_q.pop_front());
            end else begin
                mc_rsp_push = 1'b0;
                mc_rsp_data = '0;
            end
            mc_req_stall = (model_rand() % 3) == 0;
        end
    end

    // Compare process for every strobe on the memory port
    initial begin
        forever begin
            @(negedge clk);
            if (mc_req_ld === 1'b1 || mc_req_st === 1'b1) begin
                checks++;
                if (stall_sampled !== 1'b0) begin
                    errors++;
                    $display("%s: strobe raised although mc_req_stall was high", test_name);
                end
            end
            if (mc_req_ld === 1'b1) begin
                exp_addr = region + vadr_t'(ENTRY_STRIDE * (ld_count / 2))
                         + vadr_t'(8 * (ld_count % 2));
                checks++;
                if (mc_req_vadr !== exp_addr) begin
                    errors++;
                    $display("Error %s: read address expected %h actual %h",
                             test_name, exp_addr, mc_req_vadr);
                end
                ld_count++;
            end
            if (mc_req_st === 1'b1) begin
                exp_addr = region + vadr_t'(ENTRY_STRIDE * (st_count / 4))
                         + vadr_t'(8 * (st_count % 4));
                exp_data = expected_store_word(st_count / 4, st_count % 4);
                checks += 2;
                if (mc_req_vadr !== exp_addr) begin
                    errors++;
                    $display("Error %s: write address expected %h actual %h",
                             test_name, exp_addr, mc_req_vadr);
                end
                if (mc_req_wrd_rdctl !== exp_data) begin
                    errors++;
                    $display("Error %s: write data expected %h actual %h",
                             test_name, exp_data, mc_req_wrd_rdctl);
                end
                st_count++;
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 40);
        errors++;
        $display("%s: operation never ended, stall stayed high", test_name);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        opcode    = OP_IDLE;
        addr_base = 64'h0000_0012_3450_0000;
        fill_rng  = 32'h4638;
        errors    = 0;
        checks    = 0;
        ld_count  = 0;
        st_count  = 0;
        test_name = "reset";
        region    = vadr_t'(addr_base) + vadr_t'(HEADER_BYTES)
                  + vadr_t'(DATA_BYTES_PER_ENTRY * ENTRIES);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        compare_bit("stall", 1'b0, stall);
        compare_bit("mc_req_ld", 1'b0, mc_req_ld);
        compare_bit("mc_req_st", 1'b0, mc_req_st);
        compare_bit("mc_rsp_stall", 1'b0, mc_rsp_stall);

        fill_memory();
        run_op(OP_LOAD, "load_1");
        run_op(OP_STORE, "store_1");

        fill_memory();  // New contents for the reload
        run_op(OP_LOAD, "load_2");
        run_op(OP_STORE, "store_2");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/bps_top.sv */
`default_nettype none

module bps_top import bps_pkg::*; #(
    parameter int FIELD_WIDTH  = 128,
    parameter int FIELD_HEIGHT = 128
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire opcode_t     opcode,
    input  wire logic [63:0] addr_base,
    output logic             stall,
    output logic             mc_req_ld,
    output logic             mc_req_st,
    output vadr_t            mc_req_vadr,
    output word_t            mc_req_wrd_rdctl,
    input  wire logic        mc_req_stall,
    input  wire word_t       mc_rsp_data,
    input  wire logic        mc_rsp_push,
    output logic             mc_rsp_stall
);

    localparam int ENTRIES   = FIELD_WIDTH * FIELD_HEIGHT;
    localparam int ADDR_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic                 start_load;
    logic                 start_store;
    logic                 store_active;
    vadr_t                region_base;
    logic                 req_grant;
    logic                 load_done;
    logic                 store_done;
    logic                 rd_req;
    vadr_t                rd_vadr;
    logic                 wr_req;
    vadr_t                wr_vadr;
    word_t                wr_data;
    logic                 ram_we;
    logic [ADDR_BITS-1:0] ram_waddr;
    logic [ADDR_BITS-1:0] ram_raddr;
    logic [ADDR_BITS-1:0] ram_addr;
    msg_vec_t             ram_wdata;
    msg_vec_t             ram_rdata;

    assign mc_rsp_stall = 1'b0;
    assign ram_addr     = store_active ? ram_raddr : ram_waddr;  // Storer reads and loader writes

    bps_sequencer #(
        .FIELD_WIDTH  (FIELD_WIDTH),
        .FIELD_HEIGHT (FIELD_HEIGHT)
    ) i_bps_sequencer (
        .clk              (clk),
        .rst              (rst),
        .opcode           (opcode),
        .addr_base        (addr_base),
        .mc_req_stall     (mc_req_stall),
        .load_done        (load_done),
        .store_done       (store_done),
        .rd_req           (rd_req),
        .rd_vadr          (rd_vadr),
        .wr_req           (wr_req),
        .wr_vadr          (wr_vadr),
        .wr_data          (wr_data),
        .stall            (stall),
        .start_load       (start_load),
        .start_store      (start_store),
        .store_active     (store_active),
        .region_base      (region_base),
        .req_grant        (req_grant),
        .mc_req_ld        (mc_req_ld),
        .mc_req_st        (mc_req_st),
        .mc_req_vadr      (mc_req_vadr),
        .mc_req_wrd_rdctl (mc_req_wrd_rdctl)
    );

    field_loader #(
        .FIELD_WIDTH  (FIELD_WIDTH),
        .FIELD_HEIGHT (FIELD_HEIGHT)
    ) i_field_loader (
        .clk         (clk),
        .rst         (rst),
        .start_load  (start_load),
        .region_base (region_base),
        .req_grant   (req_grant),
        .mc_rsp_push (mc_rsp_push),
        .mc_rsp_data (mc_rsp_data),
        .rd_req      (rd_req),
        .rd_vadr     (rd_vadr),
        .ram_we      (ram_we),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata),
        .load_done   (load_done)
    );

    field_storer #(
        .FIELD_WIDTH      (FIELD_WIDTH),
        .FIELD_HEIGHT     (FIELD_HEIGHT),
        .FIFO_ALMOST_FULL (1)
    ) i_field_storer (
        .clk         (clk),
        .rst         (rst),
        .start_store (start_store),
        .region_base (region_base),
        .req_grant   (req_grant),
        .ram_rdata   (ram_rdata),
        .ram_raddr   (ram_raddr),
        .wr_req      (wr_req),
        .wr_vadr     (wr_vadr),
        .wr_data     (wr_data),
        .store_done  (store_done)
    );

    message_ram #(
        .ENTRIES   (ENTRIES),
        .ADDR_BITS (ADDR_BITS)
    ) i_message_ram (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* hw/bps_sequencer.sv */
`default_nettype none

module bps_sequencer import bps_pkg::*; #(
    parameter int FIELD_WIDTH  = 128,
    parameter int FIELD_HEIGHT = 128,
    localparam int ENTRIES = FIELD_WIDTH * FIELD_HEIGHT
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire opcode_t     opcode,
    input  wire logic [63:0] addr_base,
    input  wire logic        mc_req_stall,
    input  wire logic        load_done,
    input  wire logic        store_done,
    input  wire logic        rd_req,
    input  wire vadr_t       rd_vadr,
    input  wire logic        wr_req,
    input  wire vadr_t       wr_vadr,
    input  wire word_t       wr_data,
    output logic             stall,
    output logic             start_load,
    output logic             start_store,
    output logic             store_active,
    output vadr_t            region_base,
    output logic             req_grant,
    output logic             mc_req_ld,
    output logic             mc_req_st,
    output vadr_t            mc_req_vadr,
    output word_t            mc_req_wrd_rdctl
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_STORE
    } state_t;

    state_t state;

    assign req_grant    = !mc_req_stall;
    assign store_active = (state == S_STORE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            stall       <= 1'b0;
            start_load  <= 1'b0;
            start_store <= 1'b0;
        end else begin
            start_load  <= 1'b0;
            start_store <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (opcode == OP_LOAD) begin
                        state      <= S_LOAD;
                        stall      <= 1'b1;
                        start_load <= 1'b1;
                    end else if (opcode == OP_STORE) begin
                        state       <= S_STORE;
                        stall       <= 1'b1;
                        start_store <= 1'b1;
                    end
                end
                S_LOAD: begin
                    if (load_done) begin
                        state <= S_IDLE;
                        stall <= 1'b0;
                    end
                end
                S_STORE: begin
                    if (store_done) begin
                        state <= S_IDLE;
                        stall <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Region starts after the header and the skipped data-cost region
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            region_base <= vadr_t'(addr_base) + vadr_t'(HEADER_BYTES)
                         + vadr_t'(DATA_BYTES_PER_ENTRY * ENTRIES);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mc_req_ld <= 1'b0;
            mc_req_st <= 1'b0;
        end else begin
            mc_req_ld <= (state == S_LOAD) && rd_req && req_grant;
            mc_req_st <= (state == S_STORE) && wr_req && req_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_STORE) begin
            mc_req_vadr      <= wr_vadr;
            mc_req_wrd_rdctl <= wr_data;
        end else begin
            mc_req_vadr      <= rd_vadr;
            mc_req_wrd_rdctl <= '0;  // Read control word unused
        end
    end

    // The two engines never request the port in the same cycle
    assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
        else $error("bps_sequencer: load and store requests together");

endmodule

`default_nettype wire

/* hw/field_storer.sv */
`default_nettype none

module field_storer import bps_pkg::*; #(
    parameter int FIELD_WIDTH      = 128,
    parameter int FIELD_HEIGHT     = 128,
    parameter int FIFO_ALMOST_FULL = 1,
    localparam int ENTRIES   = FIELD_WIDTH * FIELD_HEIGHT,
    localparam int ADDR_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            start_store,
    input  wire vadr_t           region_base,
    input  wire logic            req_grant,
    input  wire msg_vec_t        ram_rdata,
    output logic [ADDR_BITS-1:0] ram_raddr,
    output logic                 wr_req,
    output vadr_t                wr_vadr,
    output word_t                wr_data,
    output logic                 store_done
);

    localparam int CNT_BITS = ADDR_BITS + 1;

    logic                   active;
    logic [CNT_BITS-1:0]    rd_cnt;    // Entries read from the RAM
    logic                   rd_valid;  // ram_rdata holds an entry to push
    logic                   rd_issue;
    logic [ADDR_BITS-1:0]   ent_cnt;
    logic [1:0]             wrd_cnt;
    vadr_t                  base_q;
    logic                   wr_fire;
    logic                   last_word;
    logic [2*WORD_BITS-1:0] fifo_din;
    logic                   fifo_pop;
    word_t                  fifo_dout;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   fifo_almost_full;

    // Zero-pad each label to a byte, label 0 in the low byte
    function automatic logic [2*WORD_BITS-1:0] pad_labels(input msg_vec_t m);
        logic [2*WORD_BITS-1:0] r;
        for (int i = 0; i < LABELS; i++) begin
            r[i*8 +: 8] = 8'(m[i*MESSAGE_WIDTH +: MESSAGE_WIDTH]);
        end
        return r;
    endfunction

    assign ram_raddr = rd_cnt[ADDR_BITS-1:0];

    // A read needs a free slot, counting the entry pushed this cycle
    assign rd_issue  = active && (rd_cnt < CNT_BITS'(ENTRIES))
                     && (rd_valid ? !fifo_almost_full : !fifo_full);

    assign fifo_din  = pad_labels(ram_rdata);
    assign wr_req    = active && (wrd_cnt[1] || !fifo_empty);
    assign wr_data   = wrd_cnt[1] ? '0 : fifo_dout;  // Words 2 and 3 are zero
    assign wr_vadr   = base_q + vadr_t'(ent_cnt) * vadr_t'(ENTRY_STRIDE)
                     + vadr_t'(wrd_cnt) * vadr_t'(WORD_BITS / 8);
    assign wr_fire   = wr_req && req_grant;
    assign fifo_pop  = wr_fire && !wrd_cnt[1];
    assign last_word = wr_fire && (wrd_cnt == 2'd3)
                     && (ent_cnt == ADDR_BITS'(ENTRIES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            rd_cnt     <= '0;
            rd_valid   <= 1'b0;
            ent_cnt    <= '0;
            wrd_cnt    <= '0;
            store_done <= 1'b0;
        end else begin
            rd_valid   <= rd_issue;
            store_done <= last_word;
            if (start_store) begin
                active  <= 1'b1;
                rd_cnt  <= '0;
                ent_cnt <= '0;
                wrd_cnt <= '0;
            end else begin
                if (rd_issue) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (wr_fire) begin
                    wrd_cnt <= wrd_cnt + 1'b1;
                    if (wrd_cnt == 2'd3) begin
                        ent_cnt <= ent_cnt + 1'b1;
                    end
                end
                if (last_word) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_store) begin
            base_q <= region_base;
        end
    end

    narrowing_fifo #(
        .DEPTH            (2),
        .FIFO_ALMOST_FULL (FIFO_ALMOST_FULL)
    ) i_narrowing_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (rd_valid),
        .din         (fifo_din),
        .pop         (fifo_pop),
        .dout        (fifo_dout),
        .empty       (fifo_empty),
        .full        (fifo_full),
        .almost_full (fifo_almost_full)
    );

endmodule

`default_nettype wire

/* hw/narrowing_fifo.sv */
`default_nettype none

module narrowing_fifo import bps_pkg::*; #(
    parameter int DEPTH            = 2,
    parameter int FIFO_ALMOST_FULL = 1
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   push,
    input  wire logic [2*WORD_BITS-1:0] din,
    input  wire logic                   pop,
    output word_t                       dout,
    output logic                        empty,
    output logic                        full,
    output logic                        almost_full
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [2*WORD_BITS-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;  // Wide entries held
    logic                   half;   // High word of head entry is next
    logic                   pop_entry;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop_entry   = pop && half;
    assign dout        = half ? mem[rd_ptr][2*WORD_BITS-1:WORD_BITS] : mem[rd_ptr][WORD_BITS-1:0];
    assign empty       = (count == '0);
    assign full        = (count == CNT_BITS'(DEPTH));
    assign almost_full = (count >= CNT_BITS'(DEPTH - FIFO_ALMOST_FULL));

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            half   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                half <= ~half;
            end
            if (pop_entry) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop_entry) begin
                count <= count + 1'b1;
            end else if (!push && pop_entry) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(push && full) && !(pop && empty))
        else $error("narrowing_fifo: overflow or underflow");

endmodule

`default_nettype wire

/* hw/field_loader.sv */
`default_nettype none

module field_loader import bps_pkg::*; #(
    parameter int FIELD_WIDTH  = 128,
    parameter int FIELD_HEIGHT = 128,
    localparam int ENTRIES   = FIELD_WIDTH * FIELD_HEIGHT,
    localparam int ADDR_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            start_load,
    input  wire vadr_t           region_base,
    input  wire logic            req_grant,
    input  wire logic            mc_rsp_push,
    input  wire word_t           mc_rsp_data,
    output logic                 rd_req,
    output vadr_t                rd_vadr,
    output logic                 ram_we,
    output logic [ADDR_BITS-1:0] ram_waddr,
    output msg_vec_t             ram_wdata,
    output logic                 load_done
);

    localparam int REQS      = 2 * ENTRIES;
    localparam int CNT_BITS  = $clog2(REQS + 1);
    localparam int HALF_BITS = MSG_BITS / 2;

    logic                 active;
    logic [CNT_BITS-1:0]  req_cnt;
    logic [CNT_BITS-1:0]  rsp_cnt;
    vadr_t                base_q;
    logic [HALF_BITS-1:0] lo_half;
    logic                 last_write;

    // Keep the low 6 bits of each byte
    function automatic logic [HALF_BITS-1:0] cut_labels(input word_t w);
        logic [HALF_BITS-1:0] r;
        for (int i = 0; i < HALF_BITS / MESSAGE_WIDTH; i++) begin
            r[i*MESSAGE_WIDTH +: MESSAGE_WIDTH] = w[i*8 +: MESSAGE_WIDTH];
        end
        return r;
    endfunction

    assign rd_req  = active && (req_cnt != CNT_BITS'(REQS));
    assign rd_vadr = base_q + vadr_t'(req_cnt >> 1) * vadr_t'(ENTRY_STRIDE)
                   + vadr_t'(req_cnt[0]) * vadr_t'(WORD_BITS / 8);

    assign last_write = ram_we && (ram_waddr == ADDR_BITS'(ENTRIES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            req_cnt   <= '0;
            rsp_cnt   <= '0;
            ram_we    <= 1'b0;
            load_done <= 1'b0;
        end else begin
            ram_we    <= 1'b0;
            load_done <= last_write;
            if (start_load) begin
                active  <= 1'b1;
                req_cnt <= '0;
                rsp_cnt <= '0;
            end else begin
                if (rd_req && req_grant) begin
                    req_cnt <= req_cnt + 1'b1;
                end
                if (mc_rsp_push) begin
                    rsp_cnt <= rsp_cnt + 1'b1;
                    ram_we  <= rsp_cnt[0];  // Second word completes the entry
                end
                if (last_write) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_load) begin
            base_q <= region_base;
        end
        if (mc_rsp_push) begin
            if (rsp_cnt[0]) begin
                ram_wdata <= {cut_labels(mc_rsp_data), lo_half};
                ram_waddr <= rsp_cnt[ADDR_BITS:1];
            end else begin
                lo_half <= cut_labels(mc_rsp_data);
            end
        end
    end

    // Responses only answer reads already passed to the memory port
    assert property (@(posedge clk) disable iff (rst)
        mc_rsp_push |-> active && (rsp_cnt < req_cnt))
        else $error("field_loader: response without outstanding read");

endmodule

`default_nettype wire

/* hw/message_ram.sv */
`default_nettype none

module message_ram import bps_pkg::*; #(
    parameter int ENTRIES   = 8,
    parameter int ADDR_BITS = 3
) (
    input  wire logic                 clk,
    input  wire logic                 we,
    input  wire logic [ADDR_BITS-1:0] addr,
    input  wire msg_vec_t             wdata,
    output msg_vec_t                  rdata
);

    // One horizontal message vector per field entry
    msg_vec_t mem [ENTRIES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Old data on read during write
    end

endmodule

`default_nettype wire

/* hw/bps_pkg.sv */
`default_nettype none

package bps_pkg;

    localparam int LABELS        = 16;
    localparam int MESSAGE_WIDTH = 6;
    localparam int MSG_BITS      = LABELS * MESSAGE_WIDTH;
    localparam int WORD_BITS     = 64;
    localparam int VADR_BITS     = 48;

    localparam int HEADER_BYTES         = 40;  // Field package header
    localparam int DATA_BYTES_PER_ENTRY = 16;  // Skipped data-cost region
    localparam int ENTRY_STRIDE         = 32;  // Message entry pitch in memory

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [VADR_BITS-1:0] vadr_t;
    typedef logic [MSG_BITS-1:0]  msg_vec_t;  // Label i at bits [6i+5:6i]

    typedef enum logic [2:0] {
        OP_IDLE  = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd4   // 2 and 3 reserved
    } opcode_t;

endpackage

`default_nettype wire
